//--- Bender.yml
package:
  name: board_mgmt

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/i2c_cmd_pkg.sv
      - rtl/sgmii_status_pkg.sv
      - rtl/power_on_sequencer.sv
      - rtl/si570_init_seq.sv
      - rtl/i2c_write_master.sv
      - rtl/sgmii_status_monitor.sv
      - rtl/board_mgmt_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/board_mgmt_asserts.sv
      - tb/tb_board_mgmt.sv

//--- rtl/board_mgmt_consts.svh
/* Board management constants
   Si570 address, I2C bit timing and power-up delays */

`default_nettype none

`ifndef BOARD_MGMT_CONSTS_SVH
`define BOARD_MGMT_CONSTS_SVH

// Si570 7-bit device address, write bit is appended in the table
`define SI570_I2C_ADDR 7'h5D

`define I2C_PRESCALE_DEFAULT 800  // Quarter SCL period in clocks

// Power-up wait before init, 2^20 cycles is about 8 ms at 125 MHz
`define START_DELAY_LOG2_DEFAULT 20

`define RST_SYNC_STAGES 4         // Reset synchronizer depth

`define SI570_INIT_LEN 17         // Bytes in the init table

`endif

`default_nettype wire

//--- rtl/board_mgmt_top.sv
/* Board management top level
   Reset, Si570 bring-up over I2C, PCS reset hold and SGMII status decode */

`timescale 1ns/10ps
`include "board_mgmt_consts.svh"
`default_nettype none

module board_mgmt_top
    import i2c_cmd_pkg::*;
    import sgmii_status_pkg::*;
#(
    parameter int START_DELAY_LOG2 = `START_DELAY_LOG2_DEFAULT,
    parameter int PRESCALE         = `I2C_PRESCALE_DEFAULT
) (
    input  logic          clk_125mhz_int,
    input  logic          ext_rst_i,
    input  sgmii_status_t sgmii_status_i,
    input  logic          sel_raw_i,
    inout  wire           scl_io,
    inout  wire           sda_io,
    output logic          pcs_reset_o,
    output logic          init_busy_o,
    output logic          speed_is_10_100_o,
    output logic          speed_is_100_o,
    output logic [7:0]    led_o
);

    logic     rst_125mhz_int;
    logic     init_start;
    logic     init_busy;
    i2c_cmd_t si570_cmd;
    logic     si570_cmd_valid;
    logic     si570_cmd_ready;
    logic     master_idle;
    logic     scl_o;
    logic     scl_t;
    logic     sda_o;
    logic     sda_t;

    power_on_sequencer #(
        .START_DELAY_LOG2(START_DELAY_LOG2)
    ) i_power_on_sequencer (
        .clk_125mhz_int(clk_125mhz_int),
        .ext_rst_i     (ext_rst_i),
        .rst_sync_o    (rst_125mhz_int),
        .init_start_o  (init_start)
    );

    si570_init_seq i_si570_init_seq (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .start_i       (init_start),
        .cmd_o         (si570_cmd),
        .cmd_valid_o   (si570_cmd_valid),
        .cmd_ready_i   (si570_cmd_ready),
        .master_idle_i (master_idle),
        .busy_o        (init_busy)
    );

    i2c_write_master #(
        .PRESCALE(PRESCALE)
    ) i_i2c_write_master (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .cmd_i         (si570_cmd),
        .cmd_valid_i   (si570_cmd_valid),
        .cmd_ready_o   (si570_cmd_ready),
        .idle_o        (master_idle),
        .scl_o         (scl_o),
        .scl_t_o       (scl_t),
        .sda_o         (sda_o),
        .sda_t_o       (sda_t)
    );

    sgmii_status_monitor i_sgmii_status_monitor (
        .clk_125mhz_int   (clk_125mhz_int),
        .rst_125mhz_int   (rst_125mhz_int),
        .sgmii_status_i   (sgmii_status_i),
        .sel_raw_i        (sel_raw_i),
        .speed_is_10_100_o(speed_is_10_100_o),
        .speed_is_100_o   (speed_is_100_o),
        .led_o            (led_o)
    );

    // Open-drain pads, pulled up on the board
    assign scl_io = scl_t ? 1'bz : scl_o;
    assign sda_io = sda_t ? 1'bz : sda_o;

    assign pcs_reset_o = rst_125mhz_int | init_busy;  // PCS waits for a stable refclk
    assign init_busy_o = init_busy;

endmodule

`default_nettype wire

//--- rtl/i2c_cmd_pkg.sv
/* I2C command types
   Byte stream words with start and stop framing, plus the Si570 init table */

`include "board_mgmt_consts.svh"
`default_nettype none

package i2c_cmd_pkg;

    typedef logic [7:0] i2c_byte_t;
    typedef logic [9:0] i2c_cmd_t;  // {start, stop, data}

    function automatic i2c_cmd_t mk_cmd(input logic start, input logic stop,
                                        input i2c_byte_t data);
        return {start, stop, data};
    endfunction

    function automatic logic cmd_start(input i2c_cmd_t cmd);
        return cmd[9];
    endfunction

    function automatic logic cmd_stop(input i2c_cmd_t cmd);
        return cmd[8];
    endfunction

    function automatic i2c_byte_t cmd_data(input i2c_cmd_t cmd);
        return cmd[7:0];
    endfunction

    localparam i2c_byte_t SI570_WR_ADDR = {`SI570_I2C_ADDR, 1'b0};

    // Freeze DCO, load HS_DIV/N1/RFREQ, unfreeze, then assert NewFreq
    localparam i2c_cmd_t SI570_INIT_TABLE [`SI570_INIT_LEN] = '{
        mk_cmd(1'b1, 1'b0, SI570_WR_ADDR),
        mk_cmd(1'b0, 1'b0, 8'h89),
        mk_cmd(1'b0, 1'b1, 8'h10),  // Freeze DCO
        mk_cmd(1'b1, 1'b0, SI570_WR_ADDR),
        mk_cmd(1'b0, 1'b0, 8'h07),  // Auto-increment from reg 7
        mk_cmd(1'b0, 1'b0, 8'h21),
        mk_cmd(1'b0, 1'b0, 8'h42),
        mk_cmd(1'b0, 1'b0, 8'hBC),
        mk_cmd(1'b0, 1'b0, 8'h01),
        mk_cmd(1'b0, 1'b0, 8'h1E),
        mk_cmd(1'b0, 1'b1, 8'hB8),
        mk_cmd(1'b1, 1'b0, SI570_WR_ADDR),
        mk_cmd(1'b0, 1'b0, 8'h89),
        mk_cmd(1'b0, 1'b1, 8'h00),  // Unfreeze
        mk_cmd(1'b1, 1'b0, SI570_WR_ADDR),
        mk_cmd(1'b0, 1'b0, 8'h87),
        mk_cmd(1'b0, 1'b1, 8'h40)   // NewFreq
    };

endpackage

`default_nettype wire

//--- rtl/i2c_write_master.sv
/* I2C write master
   Sends framed bytes on open-drain SCL/SDA, ack slot released and not checked */

`timescale 1ns/10ps
`include "board_mgmt_consts.svh"
`default_nettype none

module i2c_write_master
    import i2c_cmd_pkg::*;
#(
    parameter int PRESCALE = `I2C_PRESCALE_DEFAULT
) (
    input  logic     clk_125mhz_int,
    input  logic     rst_125mhz_int,
    input  i2c_cmd_t cmd_i,
    input  logic     cmd_valid_i,
    output logic     cmd_ready_o,
    output logic     idle_o,
    output logic     scl_o,
    output logic     scl_t_o,
    output logic     sda_o,
    output logic     sda_t_o
);

    localparam int PW = $clog2(PRESCALE + 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;  // 8 quarters
    localparam logic [1:0] ST_BITS  = 2'd2;  // 9 bits of 4 quarters
    localparam logic [1:0] ST_STOP  = 2'd3;  // 8 quarters

    logic [1:0]    state_q;
    logic [PW-1:0] presc_q;
    logic [2:0]    qtr_q;
    logic [3:0]    bit_q;
    logic [7:0]    shreg_q;
    logic          stop_pend_q;
    logic          bus_active_q;  // Bus owned between START and STOP
    logic          scl_q;
    logic          sda_q;
    logic          scl_next;
    logic          sda_next;
    logic          data_bit;
    logic          tick;
    logic          accept;

    assign accept   = cmd_valid_i && (state_q == ST_IDLE);
    assign tick     = (presc_q == '0);
    assign data_bit = (bit_q == 4'd8) ? 1'b1 : shreg_q[7];  // Ack slot is released

    // Line levels per quarter, 1 means released
    always_comb begin
        scl_next = 1'b1;
        sda_next = 1'b1;
        case (state_q)
            ST_IDLE: scl_next = !bus_active_q;  // SCL held low between bytes
            ST_START: begin
                scl_next = (qtr_q < 3'd2) ? !bus_active_q : 1'b1;
                sda_next = (qtr_q < 3'd6);
            end
            ST_BITS: begin
                scl_next = qtr_q[1];
                // SDA only moves in the second low quarter
                sda_next = (qtr_q == 3'd0) ? sda_q : data_bit;
            end
            default: begin
                scl_next = (qtr_q >= 3'd2);
                sda_next = (qtr_q == 3'd0) ? sda_q : (qtr_q >= 3'd6);
            end
        endcase
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            state_q      <= ST_IDLE;
            presc_q      <= '0;
            qtr_q        <= '0;
            bit_q        <= '0;
            bus_active_q <= 1'b0;
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
        end else begin
            scl_q <= scl_next;
            sda_q <= sda_next;
            if (accept) begin
                state_q <= cmd_start(cmd_i) ? ST_START : ST_BITS;
                presc_q <= PW'(PRESCALE - 1);
                qtr_q   <= '0;
                bit_q   <= '0;
            end else if (state_q != ST_IDLE && tick) begin
                presc_q <= PW'(PRESCALE - 1);
                qtr_q   <= qtr_q + 3'd1;
                case (state_q)
                    ST_START: begin
                        if (qtr_q == 3'd7) begin
                            state_q      <= ST_BITS;
                            bus_active_q <= 1'b1;
                        end
                    end
                    ST_BITS: begin
                        if (qtr_q[1:0] == 2'd3) begin
                            qtr_q <= '0;
                            if (bit_q == 4'd8) begin
                                state_q <= stop_pend_q ? ST_STOP : ST_IDLE;
                            end else begin
                                bit_q <= bit_q + 4'd1;
                            end
                        end
                    end
                    default: begin
                        if (qtr_q == 3'd7) begin
                            state_q      <= ST_IDLE;
                            bus_active_q <= 1'b0;
                        end
                    end
                endcase
            end else if (state_q != ST_IDLE) begin
                presc_q <= presc_q - PW'(1);
            end
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (accept) begin
            shreg_q     <= cmd_data(cmd_i);
            stop_pend_q <= cmd_stop(cmd_i);
        end else if (state_q == ST_BITS && tick && qtr_q[1:0] == 2'd3) begin
            shreg_q <= {shreg_q[6:0], 1'b0};  // MSB first
        end
    end

    assign cmd_ready_o = (state_q == ST_IDLE);
    assign idle_o      = (state_q == ST_IDLE) && !bus_active_q;
    assign scl_o       = 1'b0;
    assign scl_t_o     = scl_q;
    assign sda_o       = 1'b0;
    assign sda_t_o     = sda_q;

endmodule

`default_nettype wire

//--- rtl/power_on_sequencer.sv
/* Power-on sequencer
   Synchronizes the external reset and raises a delayed init start level */

`timescale 1ns/10ps
`include "board_mgmt_consts.svh"
`default_nettype none

module power_on_sequencer #(
    parameter int START_DELAY_LOG2 = `START_DELAY_LOG2_DEFAULT
) (
    input  logic clk_125mhz_int,
    input  logic ext_rst_i,
    output logic rst_sync_o,
    output logic init_start_o
);

    // Powers up asserted so the FPGA starts in reset
    logic [`RST_SYNC_STAGES-1:0] rst_sync_q = '1;
    logic [START_DELAY_LOG2:0]   delay_cnt_q;

    always_ff @(posedge clk_125mhz_int) begin
        rst_sync_q <= {rst_sync_q[`RST_SYNC_STAGES-2:0], ext_rst_i};
    end

    assign rst_sync_o = rst_sync_q[`RST_SYNC_STAGES-1];

    // Counts until the top bit sets, then holds
    always_ff @(posedge clk_125mhz_int) begin
        if (rst_sync_o) begin
            delay_cnt_q <= '0;
        end else if (!delay_cnt_q[START_DELAY_LOG2]) begin
            delay_cnt_q <= delay_cnt_q + 1'b1;
        end
    end

    assign init_start_o = delay_cnt_q[START_DELAY_LOG2];

endmodule

`default_nettype wire

//--- rtl/sgmii_status_monitor.sv
/* SGMII status monitor
   Registers speed-control flags and an LED view of the PCS status word */

`timescale 1ns/10ps
`default_nettype none

module sgmii_status_monitor
    import sgmii_status_pkg::*;
(
    input  logic          clk_125mhz_int,
    input  logic          rst_125mhz_int,
    input  sgmii_status_t sgmii_status_i,
    input  logic          sel_raw_i,
    output logic          speed_is_10_100_o,
    output logic          speed_is_100_o,
    output logic [7:0]    led_o
);

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            speed_is_10_100_o <= 1'b0;
            speed_is_100_o    <= 1'b0;
            led_o             <= '0;
        end else begin
            speed_is_10_100_o <= (sgmii_status_i.fld.speed != SGMII_SPEED_1000);
            speed_is_100_o    <= (sgmii_status_i.fld.speed == SGMII_SPEED_100);
            if (sel_raw_i) begin
                led_o <= sgmii_status_i.raw[7:0];  // Raw low byte
            end else begin
                led_o <= {sgmii_status_i.fld.remote_fault,
                          sgmii_status_i.fld.duplex,
                          sgmii_status_i.fld.speed,
                          sgmii_status_i.fld.phy_link,
                          sgmii_status_i.fld.rudi_invalid,
                          sgmii_status_i.fld.link_sync,
                          sgmii_status_i.fld.link_status};
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/sgmii_status_pkg.sv
/* SGMII PCS status types
   The 16-bit status word as raw bits or as named fields */

`default_nettype none

package sgmii_status_pkg;

    typedef enum logic [1:0] {
        SGMII_SPEED_10   = 2'd0,
        SGMII_SPEED_100  = 2'd1,
        SGMII_SPEED_1000 = 2'd2
    } sgmii_speed_e;

    // Declared MSB first, bit 0 is link_status
    typedef struct packed {
        logic [1:0]   pause;
        logic         remote_fault;
        logic         duplex;
        sgmii_speed_e speed;
        logic [1:0]   remote_fault_enc;
        logic         phy_link;
        logic         rx_not_in_table;
        logic         rx_disp_err;
        logic         rudi_invalid;
        logic         rudi_i;
        logic         rudi_c;
        logic         link_sync;
        logic         link_status;
    } sgmii_status_fields_t;

    typedef union packed {
        logic [15:0]          raw;
        sgmii_status_fields_t fld;
    } sgmii_status_t;

endpackage

`default_nettype wire

//--- rtl/si570_init_seq.sv
/* Si570 init sequencer
   Feeds the register-write table to the I2C master once per reset */

`timescale 1ns/10ps
`include "board_mgmt_consts.svh"
`default_nettype none

module si570_init_seq
    import i2c_cmd_pkg::*;
(
    input  logic     clk_125mhz_int,
    input  logic     rst_125mhz_int,
    input  logic     start_i,
    output i2c_cmd_t cmd_o,
    output logic     cmd_valid_o,
    input  logic     cmd_ready_i,
    input  logic     master_idle_i,
    output logic     busy_o
);

    localparam int IDX_W = $clog2(`SI570_INIT_LEN);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`SI570_INIT_LEN - 1);

    localparam logic [1:0] ST_WAIT  = 2'd0;  // Waiting for power-up delay
    localparam logic [1:0] ST_SEND  = 2'd1;
    localparam logic [1:0] ST_FLUSH = 2'd2;  // Last byte on the wire
    localparam logic [1:0] ST_DONE  = 2'd3;

    logic [1:0]       state_q;
    logic [IDX_W-1:0] idx_q;
    logic             busy_q;

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            state_q <= ST_WAIT;
            idx_q   <= '0;
            busy_q  <= 1'b1;
        end else begin
            case (state_q)
                ST_WAIT: begin
                    if (start_i) begin
                        state_q <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (cmd_ready_i) begin
                        if (idx_q == LAST_IDX) begin
                            state_q <= ST_FLUSH;
                        end else begin
                            idx_q <= idx_q + 1'b1;  // Next word shows up next cycle
                        end
                    end
                end
                ST_FLUSH: begin
                    // Master left idle on the accept edge, so this waits out the STOP
                    if (master_idle_i) begin
                        state_q <= ST_DONE;
                        busy_q  <= 1'b0;
                    end
                end
                default: begin
                    state_q <= ST_DONE;  // Stays here until the next reset
                end
            endcase
        end
    end

    assign cmd_valid_o = (state_q == ST_SEND);
    assign cmd_o       = SI570_INIT_TABLE[idx_q];
    assign busy_o      = busy_q;

endmodule

`default_nettype wire

//--- tb.f
+incdir+rtl
rtl/i2c_cmd_pkg.sv
rtl/sgmii_status_pkg.sv
rtl/power_on_sequencer.sv
rtl/si570_init_seq.sv
rtl/i2c_write_master.sv
rtl/sgmii_status_monitor.sv
rtl/board_mgmt_top.sv
tb/board_mgmt_asserts.sv
tb/tb_board_mgmt.sv

//--- tb/board_mgmt_asserts.sv
/* I2C master assertions
   Bus framing and command handshake, bound into the master */

`timescale 1ns/10ps
`default_nettype none

module board_mgmt_asserts
    import i2c_cmd_pkg::*;
(
    input logic       clk_125mhz_int,
    input logic       rst_125mhz_int,
    input i2c_cmd_t   cmd_i,
    input logic       cmd_valid_i,
    input logic       cmd_ready_i,
    input logic       scl_t_i,
    input logic       sda_t_i,
    input logic [1:0] state_i
);

    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_STOP  = 2'd3;

    int fail_cnt = 0;  // Read by the testbench at the end of the run

    // With SCL high, SDA may only fall for START or rise for STOP
    sda_framing_a: assert property (@(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        (scl_t_i && $past(scl_t_i) && $changed(sda_t_i)) |->
            ((state_i == ST_START && !sda_t_i) || (state_i == ST_STOP && sda_t_i)))
    else begin
        fail_cnt++;
        $error("SDA changed while SCL high outside START or STOP");
    end

    cmd_hold_a: assert property (@(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        (cmd_valid_i && !cmd_ready_i) |=> (cmd_valid_i && $stable(cmd_i)))
    else begin
        fail_cnt++;
        $error("Command dropped or changed before it was accepted");
    end

endmodule

bind i2c_write_master board_mgmt_asserts i_board_mgmt_asserts (
    .clk_125mhz_int(clk_125mhz_int),
    .rst_125mhz_int(rst_125mhz_int),
    .cmd_i         (cmd_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_i   (cmd_ready_o),
    .scl_t_i       (scl_t_o),
    .sda_t_i       (sda_t_o),
    .state_i       (state_q)
);

`default_nettype wire

//--- tb/tb_board_mgmt.sv
/* Board management testbench
   I2C slave model, Si570 init capture, PCS reset hold and status decode checks */

`timescale 1ns/10ps
`include "board_mgmt_consts.svh"
`default_nettype none

module tb_board_mgmt
    import i2c_cmd_pkg::*;
    import sgmii_status_pkg::*;
();

    localparam int START_DELAY_LOG2 = 6;
    localparam int PRESCALE         = 4;
    localparam int RESET_CYCLES     = 16;
    localparam int N_STATUS         = 200;
    localparam int N_TXN            = 4;
    // Each byte is 36 quarters, START and STOP are 8 quarters each
    localparam int I2C_CYCLES  = (`SI570_INIT_LEN * 36 + N_TXN * 16) * PRESCALE;
    localparam int SEQ_CYCLES  = RESET_CYCLES + `RST_SYNC_STAGES + (1 << START_DELAY_LOG2)
                                 + I2C_CYCLES;
    localparam int WDOG_CYCLES = 2 * SEQ_CYCLES + N_STATUS + 20;

    localparam logic [7:0] ADDR_WR = {`SI570_I2C_ADDR, 1'b0};
    // Register and data bytes of the four writes, address byte excluded
    localparam logic [7:0] REG_BYTES [13] = '{8'h89, 8'h10, 8'h07, 8'h21, 8'h42, 8'hBC,
                                             8'h01, 8'h1E, 8'hB8, 8'h89, 8'h00, 8'h87,
                                             8'h40};
    localparam int TXN_LEN [N_TXN] = '{2, 7, 2, 2};

    logic          clk_125mhz_int;
    logic          ext_rst;
    sgmii_status_t sgmii_status;
    logic          sel_raw;
    wire           scl_io;
    wire           sda_io;
    logic          pcs_reset;
    logic          init_busy;
    logic          speed_is_10_100;
    logic          speed_is_100;
    logic [7:0]    led;

    // Slave model and bookkeeping
    i2c_cmd_t got_q[$];
    i2c_cmd_t exp_q[$];
    logic     [7:0] shreg = '0;
    int       bit_cnt = 0;
    logic     in_xfer = 1'b0;
    logic     start_pend = 1'b0;
    logic     ack_drive = 1'b0;
    int       stop_cnt = 0;
    int       cyc = 0;
    int       first_sda_cyc = -1;
    logic     pcs_fell = 1'b0;
    logic     pcs_rose = 1'b0;
    int       err_cnt = 0;
    int       check_cnt = 0;
    int       speed_bad = 0;
    int       led_bad = 0;

    pullup pu_scl (scl_io);
    pullup pu_sda (sda_io);
    assign sda_io = ack_drive ? 1'b0 : 1'bz;

    board_mgmt_top #(
        .START_DELAY_LOG2(START_DELAY_LOG2),
        .PRESCALE        (PRESCALE)
    ) i_board_mgmt_top (
        .clk_125mhz_int   (clk_125mhz_int),
        .ext_rst_i        (ext_rst),
        .sgmii_status_i   (sgmii_status),
        .sel_raw_i        (sel_raw),
        .scl_io           (scl_io),
        .sda_io           (sda_io),
        .pcs_reset_o      (pcs_reset),
        .init_busy_o      (init_busy),
        .speed_is_10_100_o(speed_is_10_100),
        .speed_is_100_o   (speed_is_100),
        .led_o            (led)
    );

    initial begin
        clk_125mhz_int = 1'b0;
        forever #4 clk_125mhz_int = ~clk_125mhz_int;
    end

    always @(posedge clk_125mhz_int) cyc <= cyc + 1;

    always @(negedge sda_io) begin
        if (first_sda_cyc < 0 && sda_io === 1'b0) begin
            first_sda_cyc = cyc;
        end
        if (scl_io === 1'b1) begin  // START
            in_xfer    = 1'b1;
            start_pend = 1'b1;
            bit_cnt    = 0;
        end
    end

    always @(posedge sda_io) begin
        i2c_cmd_t last;
        if (scl_io === 1'b1 && in_xfer) begin  // STOP closes the last byte
            in_xfer = 1'b0;
            stop_cnt++;
            if (got_q.size() > 0) begin
                last    = got_q.pop_back();
                last[8] = 1'b1;
                got_q.push_back(last);
            end
        end
    end

    always @(posedge scl_io) begin
        if (in_xfer) begin
            if (bit_cnt < 8) begin
                shreg = {shreg[6:0], sda_io};  // MSB first
                if (bit_cnt == 7) begin
                    got_q.push_back({start_pend, 1'b0, shreg});
                    start_pend = 1'b0;
                end
            end
            bit_cnt = (bit_cnt == 8) ? 0 : bit_cnt + 1;
        end
    end

    // Ack held low through the ninth clock
    always @(negedge scl_io) ack_drive = in_xfer && (bit_cnt == 8);

    always @(posedge pcs_reset) begin
        if (pcs_fell) begin
            pcs_rose = 1'b1;
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk_125mhz_int);
        $display("Watchdog expired after %0d cycles, the run stalled", WDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic build_expected_table();
        int t;
        int b;
        int k;
        k = 0;
        for (t = 0; t < N_TXN; t++) begin
            exp_q.push_back({1'b1, 1'b0, ADDR_WR});
            for (b = 0; b < TXN_LEN[t]; b++) begin
                exp_q.push_back({1'b0, (b == TXN_LEN[t] - 1), REG_BYTES[k]});
                k++;
            end
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_cmd(input i2c_cmd_t got, input i2c_cmd_t exp, input int idx);
        check_cnt++;
        if (got !== exp) begin
            $display("ERR %0t: byte %0d start/stop/data got %b/%b/%h expected %b/%b/%h",
                     $time, idx, got[9], got[8], got[7:0], exp[9], exp[8], exp[7:0]);
            err_cnt++;
        end
    endtask

    task automatic check_status_out(input sgmii_status_t word, input logic sel);
        logic [1:0] spd;
        logic [7:0] exp_led;
        spd     = word.raw[11:10];
        exp_led = sel ? word.raw[7:0]
                      : {word.raw[13:10], word.raw[7], word.raw[4], word.raw[1:0]};
        check_cnt++;
        if (speed_is_10_100 !== (spd != 2'd2) || speed_is_100 !== (spd == 2'd1)) begin
            $display("ERR %0t: status %h speed flags got %b%b", $time, word.raw,
                     speed_is_10_100, speed_is_100);
            err_cnt++;
            speed_bad++;
        end
        check_cnt++;
        if (led !== exp_led) begin
            $display("ERR %0t: status %h sel %b led got %h expected %h", $time, word.raw,
                     sel, led, exp_led);
            err_cnt++;
            led_bad++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        $display("Test %s finished, %0d errors", name, errs);
    endtask

    initial begin
        int            i;
        int            errs_before;
        int            rel_cyc;
        int            assert_fails;
        logic [31:0]   rnd;
        sgmii_status_t word;
        logic          sel;

        ext_rst      = 1'b1;
        sgmii_status = 16'hF7FF;  // 100 Mb/s with all low bits set
        sel_raw      = 1'b1;
        build_expected_table();

        repeat (RESET_CYCLES) @(posedge clk_125mhz_int);
        #1 ext_rst = 1'b0;
        rel_cyc = cyc + `RST_SYNC_STAGES;

        // 1: levels right after reset release
        errs_before = err_cnt;
        repeat (`RST_SYNC_STAGES) @(posedge clk_125mhz_int);
        #1;
        check_bit(scl_io, 1'b1, "SCL after reset");
        check_bit(sda_io, 1'b1, "SDA after reset");
        check_bit(pcs_reset, 1'b1, "pcs_reset_o after reset");
        check_bit(init_busy, 1'b1, "init_busy_o after reset");
        check_bit(speed_is_10_100, 1'b0, "speed_is_10_100_o after reset");
        check_bit(speed_is_100, 1'b0, "speed_is_100_o after reset");
        check_bit(led === 8'h00, 1'b1, "led_o zero after reset");
        report_test("1 reset levels", err_cnt - errs_before);

        do begin
            @(posedge clk_125mhz_int);
            #1;
        end while (pcs_reset !== 1'b0);
        pcs_fell = 1'b1;

        // 2: start delay
        errs_before = err_cnt;
        if (first_sda_cyc < 0) begin
            $display("No SDA fall was seen before init finished");
            err_cnt++;
        end else begin
            check_bit(first_sda_cyc - rel_cyc >= (1 << START_DELAY_LOG2), 1'b1,
                      "first SDA fall after start delay");
        end
        report_test("2 start delay", err_cnt - errs_before);

        // 3: captured bytes and framing
        errs_before = err_cnt;
        if (got_q.size() != `SI570_INIT_LEN) begin
            $display("Slave captured %0d bytes instead of %0d", got_q.size(),
                     `SI570_INIT_LEN);
            err_cnt++;
        end
        for (i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_cmd(got_q[i], exp_q[i], i);
        end
        report_test("3 Si570 writes", err_cnt - errs_before);

        // 5 and 6: random status words, one cycle latency
        errs_before = err_cnt;
        check_bit(stop_cnt == N_TXN, 1'b1, "all STOPs seen before pcs_reset_o fell");
        check_bit(in_xfer, 1'b0, "bus idle when pcs_reset_o fell");
        speed_bad = 0;
        led_bad   = 0;
        rnd       = 32'd314;
        for (i = 0; i < N_STATUS; i++) begin
            rnd          = next_random(rnd);
            word.raw     = rnd[31:16];
            rnd          = next_random(rnd);
            sel          = rnd[31];
            sgmii_status = word;
            sel_raw      = sel;
            @(posedge clk_125mhz_int);
            #1;
            check_status_out(word, sel);
        end
        report_test("5 speed flags", speed_bad);
        report_test("6 LED view", led_bad);

        // 4: PCS reset released after the last STOP and held low
        check_bit(pcs_rose, 1'b0, "pcs_reset_o stayed low");
        check_bit(pcs_reset, 1'b0, "pcs_reset_o at end");
        check_bit(init_busy, 1'b0, "init_busy_o at end");
        report_test("4 PCS reset release", err_cnt - errs_before - speed_bad - led_bad);

        assert_fails = i_board_mgmt_top.i_i2c_write_master.i_board_mgmt_asserts.fail_cnt;
        err_cnt = err_cnt + assert_fails;
        $display("Checks %0d, errors %0d, assertion failures %0d", check_cnt, err_cnt,
                 assert_fails);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
